//--- build.f
+incdir+common
+incdir+tests
common/fe_pkg.sv
src/fe_pc_gen.sv
src/fe_fetch_stage.sv
src/fe_controller.sv
src/fe_top.sv
tests/fe_tb.sv

//--- run.sh
#!/bin/sh
# Builds the front end testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --timescale 1ns/1ps \
  --top-module fe_tb -Mdir obj_dir -o fe_tb_sim -f build.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/fe_tb_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation ended with status $status"
  exit "$status"
fi

exit 0

//--- tests/fe_tb_checks.svh
// LFSR, compare tasks and directed tests of the front end testbench, included inside fe_tb
`ifndef FE_TB_CHECKS_SVH
`define FE_TB_CHECKS_SVH

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  // Aligned fetch target built from fresh LFSR bits
  function automatic fe_pkg::vaddr_t random_target();
    fe_pkg::vaddr_t v;
    int             i;
    v = '0;
    for (i = 0; i < `FE_VADDR_WIDTH - `FE_ALIGN_BITS; i++)
      v = {v[`FE_VADDR_WIDTH-2:0], lfsr_bit()};
    return v << `FE_ALIGN_BITS;
  endfunction

  task automatic compare_vaddr(input string test_name, input fe_pkg::vaddr_t exp_pc,
                               input fe_pkg::vaddr_t act_pc);
    if (act_pc !== exp_pc)
      end_with_failure($sformatf("FAIL %s: expected pc %h, actual %h", test_name, exp_pc, act_pc));
  endtask

  task automatic compare_instr(input string test_name, input fe_pkg::instr_t exp_instr,
                               input fe_pkg::instr_t act_instr);
    if (act_instr !== exp_instr)
      end_with_failure($sformatf("FAIL %s: expected instr %h, actual %h",
                                 test_name, exp_instr, act_instr));
  endtask

  task automatic compare_msg(input string test_name, input fe_pkg::fe_msg_e exp_msg,
                             input fe_pkg::fe_msg_e act_msg);
    if (act_msg !== exp_msg)
      end_with_failure($sformatf("FAIL %s: expected message %s, actual %s",
                                 test_name, exp_msg.name(), act_msg.name()));
  endtask

  task automatic compare_exc(input string test_name, input fe_pkg::fe_exc_e exp_exc,
                             input fe_pkg::fe_exc_e act_exc);
    if (act_exc !== exp_exc)
      end_with_failure($sformatf("FAIL %s: expected code %s, actual %s",
                                 test_name, exp_exc.name(), act_exc.name()));
  endtask

  task automatic send_cmd(input fe_pkg::fe_opcode_e op, input fe_pkg::vaddr_t addr);
    fe_cmd_v_i      = 1'b1;
    fe_cmd_opcode_i = op;
    fe_cmd_vaddr_i  = addr;
    @(negedge clk_i);
    fe_cmd_v_i = 1'b0;
  endtask

  task automatic wait_messages(input string test_name, input int total);
    int cycles;
    cycles = 0;
    while (pc_q.size() < total)
    begin
      if (cycles == CYCLES_PER_TEST)
        end_with_failure($sformatf("%s: the expected queue messages did not arrive", test_name));
      @(negedge clk_i);
      cycles++;
    end
  endtask

  // Consecutive fetch messages starting at first_pc
  task automatic check_fetches(input string test_name, input int first,
                               input fe_pkg::vaddr_t first_pc, input int count);
    fe_pkg::vaddr_t pc;
    int             i;
    pc = first_pc;
    for (i = first; i < first + count; i++)
    begin
      compare_msg(test_name, fe_pkg::e_msg_fetch, msg_q[i]);
      compare_vaddr(test_name, pc, pc_q[i]);
      compare_instr(test_name, model_data(pc), instr_q[i]);
      compare_exc(test_name, fe_pkg::e_exc_none, exc_q[i]);
      pc = pc + fe_pkg::vaddr_t'(`FE_INSTR_BYTES);
    end
  endtask

  task automatic check_exception(input string test_name, input int idx, input fe_pkg::vaddr_t pc,
                                 input fe_pkg::fe_exc_e code);
    compare_msg(test_name, fe_pkg::e_msg_exception, msg_q[idx]);
    compare_vaddr(test_name, pc, pc_q[idx]);
    compare_instr(test_name, '0, instr_q[idx]);
    compare_exc(test_name, code, exc_q[idx]);
  endtask

  task automatic expect_silence(input string test_name, input int cycles);
    int msgs;
    int issues;
    msgs   = pc_q.size();
    issues = issue_count;
    repeat (cycles) @(negedge clk_i);
    if (pc_q.size() != msgs)
      end_with_failure($sformatf("%s: a queue message appeared while fetching was stopped",
                                 test_name));
    if (issue_count != issues)
      end_with_failure($sformatf("%s: a fetch was issued while fetching was stopped", test_name));
  endtask

  task automatic test_idle_after_reset();
    fe_queue_ready_i = 1'b1;
    expect_silence("idle_after_reset", 20);
  endtask

  task automatic test_sequential_fetch();
    fe_pkg::vaddr_t target;
    int             base;
    target = random_target();
    base   = pc_q.size();
    send_cmd(fe_pkg::e_op_pc_redirect, target);
    wait_messages("sequential_fetch", base + 8);
    check_fetches("sequential_fetch", base, target, 8);
  endtask

  // Random ready; refused fetches must be replayed without gaps or repeats
  task automatic test_ready_backpressure();
    fe_pkg::vaddr_t target;
    int             base;
    int             cycles;
    target = random_target();
    base   = pc_q.size();
    cycles = 0;
    send_cmd(fe_pkg::e_op_pc_redirect, target);
    while (pc_q.size() < base + 10)
    begin
      if (cycles == CYCLES_PER_TEST)
        end_with_failure("ready_backpressure: the stream stopped under back-pressure");
      fe_queue_ready_i = lfsr_bit();
      @(negedge clk_i);
      cycles++;
    end
    fe_queue_ready_i = 1'b1;
    check_fetches("ready_backpressure", base, target, 10);
  endtask

  task automatic test_redirect_mid_stream();
    fe_pkg::vaddr_t first_target;
    fe_pkg::vaddr_t second_target;
    int             base;
    int             mid;
    first_target  = random_target();
    second_target = random_target();
    base          = pc_q.size();
    send_cmd(fe_pkg::e_op_pc_redirect, first_target);
    wait_messages("redirect_mid_stream", base + 4);
    mid = pc_q.size();
    send_cmd(fe_pkg::e_op_pc_redirect, second_target);
    wait_messages("redirect_mid_stream", mid + 6);
    check_fetches("redirect_mid_stream", base, first_target, mid - base);
    check_fetches("redirect_mid_stream", mid, second_target, 6);
  endtask

  task automatic test_state_reset_and_wait();
    fe_pkg::vaddr_t target;
    fe_pkg::vaddr_t resume;
    int             base;
    target = random_target();
    resume = random_target();
    base   = pc_q.size();
    send_cmd(fe_pkg::e_op_state_reset, target);
    wait_messages("state_reset_and_wait", base + 5);
    check_fetches("state_reset_and_wait", base, target, 5);
    send_cmd(fe_pkg::e_op_wait, random_target());
    expect_silence("state_reset_and_wait", 20);
    base = pc_q.size();
    send_cmd(fe_pkg::e_op_pc_redirect, resume);
    wait_messages("state_reset_and_wait", base + 3);
    check_fetches("state_reset_and_wait", base, resume, 3);
  endtask

  task automatic test_exceptions();
    fe_pkg::vaddr_t target;
    int             base;
    target = random_target() | fe_pkg::vaddr_t'(2);
    base   = pc_q.size();
    send_cmd(fe_pkg::e_op_pc_redirect, target);
    wait_messages("misaligned_exception", base + 1);
    check_exception("misaligned_exception", base, target, fe_pkg::e_exc_misaligned);
    expect_silence("misaligned_exception", 20);
    // Window opens five fetches after the target
    target   = random_target();
    fault_lo = target + fe_pkg::vaddr_t'(5 * `FE_INSTR_BYTES);
    fault_hi = fault_lo + fe_pkg::vaddr_t'(16 * `FE_INSTR_BYTES);
    base     = pc_q.size();
    send_cmd(fe_pkg::e_op_pc_redirect, target);
    wait_messages("access_fault_exception", base + 6);
    check_fetches("access_fault_exception", base, target, 5);
    check_exception("access_fault_exception", base + 5, fault_lo, fe_pkg::e_exc_access_fault);
    expect_silence("access_fault_exception", 20);
    fault_lo = '0;
    fault_hi = '0;
  endtask

`endif

//--- tests/fe_tb.sv
// Testbench top for the fetch front end; drives fe_top through the directed tests, run by run.sh
`timescale 1ns/1ps
`default_nettype none

`include "fe_cfg.svh"

module fe_tb;

  localparam int          CLK_HALF        = 5;
  localparam int          RESET_CYCLES    = 10;
  localparam int          NUM_TESTS       = 6;
  localparam int          CYCLES_PER_TEST = 200;
  localparam logic [31:0] DATA_KEY        = 32'h5a5a_c3c3;

  logic               clk_i            = 1'b0;
  logic               reset_i          = 1'b1;
  logic               fe_cmd_v_i       = 1'b0;
  fe_pkg::fe_opcode_e fe_cmd_opcode_i  = fe_pkg::e_op_wait;
  fe_pkg::vaddr_t     fe_cmd_vaddr_i   = '0;
  logic               fe_cmd_yumi_o;
  logic               imem_v_o;
  fe_pkg::vaddr_t     imem_addr_o;
  fe_pkg::instr_t     imem_data_i      = '0;
  logic               imem_fault_i     = 1'b0;
  logic               fe_queue_v_o;
  fe_pkg::fe_msg_e    fe_queue_msg_o;
  fe_pkg::vaddr_t     fe_queue_pc_o;
  fe_pkg::instr_t     fe_queue_instr_o;
  fe_pkg::fe_exc_e    fe_queue_exc_o;
  logic               fe_queue_ready_i = 1'b0;

  // Faulting window is [fault_lo, fault_hi) and is empty when both are equal
  fe_pkg::vaddr_t     fault_lo    = '0;
  fe_pkg::vaddr_t     fault_hi    = '0;
  logic               req_v       = 1'b0;
  fe_pkg::vaddr_t     req_addr    = '0;
  int                 issue_count = 0;
  logic [31:0]        lfsr_state  = 32'hed5e_a10b;

  // Delivered queue messages in arrival order
  fe_pkg::fe_msg_e    msg_q[$];
  fe_pkg::vaddr_t     pc_q[$];
  fe_pkg::instr_t     instr_q[$];
  fe_pkg::fe_exc_e    exc_q[$];

  fe_top u_dut
  (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .fe_cmd_v_i       (fe_cmd_v_i),
    .fe_cmd_opcode_i  (fe_cmd_opcode_i),
    .fe_cmd_vaddr_i   (fe_cmd_vaddr_i),
    .fe_cmd_yumi_o    (fe_cmd_yumi_o),
    .imem_v_o         (imem_v_o),
    .imem_addr_o      (imem_addr_o),
    .imem_data_i      (imem_data_i),
    .imem_fault_i     (imem_fault_i),
    .fe_queue_v_o     (fe_queue_v_o),
    .fe_queue_msg_o   (fe_queue_msg_o),
    .fe_queue_pc_o    (fe_queue_pc_o),
    .fe_queue_instr_o (fe_queue_instr_o),
    .fe_queue_exc_o   (fe_queue_exc_o),
    .fe_queue_ready_i (fe_queue_ready_i)
  );

  always #CLK_HALF clk_i = ~clk_i;

  task automatic end_with_failure(input string reason);
    $display("%s", reason);
    $display("Testbench failed");
    $fatal(1, "stopping at the first error");
  endtask

  // Memory contents are the address XOR a fixed key
  function automatic fe_pkg::instr_t model_data(input fe_pkg::vaddr_t addr);
    return fe_pkg::instr_t'(addr) ^ fe_pkg::instr_t'(DATA_KEY);
  endfunction

  // Memory answers at the falling edge after a request and samples the next one before the rise
  always @(negedge clk_i)
  begin
    imem_data_i  = model_data(req_addr);
    imem_fault_i = req_v && (req_addr >= fault_lo) && (req_addr < fault_hi);
    #(CLK_HALF - 1);
    req_v    = imem_v_o && !reset_i;
    req_addr = imem_addr_o;
    if (!reset_i)
    begin
      if (imem_v_o === 1'b1)
        issue_count++;
      if (fe_cmd_yumi_o !== fe_cmd_v_i)
        end_with_failure("A command was not consumed in the cycle it was offered");
      if (fe_queue_v_o === 1'b1)
      begin
        if (fe_queue_ready_i !== 1'b1)
          end_with_failure("Queue valid was raised while ready was low");
        msg_q.push_back(fe_queue_msg_o);
        pc_q.push_back(fe_queue_pc_o);
        instr_q.push_back(fe_queue_instr_o);
        exc_q.push_back(fe_queue_exc_o);
      end
    end
  end

  `include "fe_tb_checks.svh"

  initial
  begin
    repeat (RESET_CYCLES + NUM_TESTS * CYCLES_PER_TEST) @(posedge clk_i);
    end_with_failure("Watchdog timeout, the tests did not finish in the allowed number of cycles");
  end

  initial
  begin
    repeat (RESET_CYCLES) @(negedge clk_i);
    reset_i = 1'b0;
    test_idle_after_reset();
    test_sequential_fetch();
    test_ready_backpressure();
    test_redirect_mid_stream();
    test_state_reset_and_wait();
    test_exceptions();
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- src/fe_top.sv
// Fetch front end top level; connects controller, pc generator and fetch pipeline to the ports
`timescale 1ns/1ps
`default_nettype none

module fe_top
(
  input  wire logic          clk_i,
  input  wire logic          reset_i,

  input  wire logic          fe_cmd_v_i,
  input  fe_pkg::fe_opcode_e fe_cmd_opcode_i,
  input  fe_pkg::vaddr_t     fe_cmd_vaddr_i,
  output logic               fe_cmd_yumi_o,

  output logic               imem_v_o,
  output fe_pkg::vaddr_t     imem_addr_o,
  input  fe_pkg::instr_t     imem_data_i,
  input  wire logic          imem_fault_i,

  output logic               fe_queue_v_o,
  output fe_pkg::fe_msg_e    fe_queue_msg_o,
  output fe_pkg::vaddr_t     fe_queue_pc_o,
  output fe_pkg::instr_t     fe_queue_instr_o,
  output fe_pkg::fe_exc_e    fe_queue_exc_o,
  input  wire logic          fe_queue_ready_i
);

  logic           issue_v;
  logic           redirect_v;
  fe_pkg::vaddr_t redirect_pc;
  logic           kill_if1;
  logic           cmd_hold;
  fe_pkg::vaddr_t issue_pc;
  fe_pkg::vaddr_t if2_pc;
  logic           fetch_fail;
  logic           exc_sent;

  fe_controller u_controller
  (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .fe_cmd_v_i       (fe_cmd_v_i),
    .fe_queue_ready_i (fe_queue_ready_i),
    .fetch_fail_i     (fetch_fail),
    .exc_sent_i       (exc_sent),
    .fe_cmd_opcode_i  (fe_cmd_opcode_i),
    .fe_cmd_vaddr_i   (fe_cmd_vaddr_i),
    .if2_pc_i         (if2_pc),
    .fe_cmd_yumi_o    (fe_cmd_yumi_o),
    .issue_v_o        (issue_v),
    .redirect_v_o     (redirect_v),
    .kill_o           (kill_if1),
    .hold_o           (cmd_hold),
    .redirect_pc_o    (redirect_pc)
  );

  fe_pc_gen u_pc_gen
  (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .redirect_v_i  (redirect_v),
    .issue_v_i     (issue_v),
    .redirect_pc_i (redirect_pc),
    .issue_pc_o    (issue_pc),
    .if2_pc_o      (if2_pc)
  );

  fe_fetch_stage u_fetch_stage
  (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .issue_v_i        (issue_v),
    .kill_i           (kill_if1),
    .hold_i           (cmd_hold),
    .imem_fault_i     (imem_fault_i),
    .fe_queue_ready_i (fe_queue_ready_i),
    .imem_data_i      (imem_data_i),
    .if2_pc_i         (if2_pc),
    .fe_queue_v_o     (fe_queue_v_o),
    .fetch_fail_o     (fetch_fail),
    .exc_sent_o       (exc_sent),
    .fe_queue_msg_o   (fe_queue_msg_o),
    .fe_queue_pc_o    (fe_queue_pc_o),
    .fe_queue_instr_o (fe_queue_instr_o),
    .fe_queue_exc_o   (fe_queue_exc_o)
  );

  // Every issue is a memory request
  assign imem_v_o    = issue_v;
  assign imem_addr_o = issue_pc;

endmodule

`default_nettype wire

//--- src/fe_controller.sv
// Front end controller; decodes commands and runs the wait/run/stall machine with poisoning
`timescale 1ns/1ps
`default_nettype none

module fe_controller
(
  input  wire logic          clk_i,
  input  wire logic          reset_i,
  input  wire logic          fe_cmd_v_i,
  input  wire logic          fe_queue_ready_i,
  input  wire logic          fetch_fail_i,
  input  wire logic          exc_sent_i,
  input  fe_pkg::fe_opcode_e fe_cmd_opcode_i,
  input  fe_pkg::vaddr_t     fe_cmd_vaddr_i,
  input  fe_pkg::vaddr_t     if2_pc_i,
  output logic               fe_cmd_yumi_o,
  output logic               issue_v_o,
  output logic               redirect_v_o,
  output logic               kill_o,
  output logic               hold_o,
  output fe_pkg::vaddr_t     redirect_pc_o
);

  fe_pkg::fe_state_e state_r;
  fe_pkg::fe_state_e state_n;
  fe_pkg::vaddr_t    resume_pc_r;
  logic              wait_pending_r;
  logic              redirect_cmd;
  logic              state_reset_cmd;
  logic              wait_cmd;
  logic              unstall;

  assign redirect_cmd    = fe_cmd_v_i & (fe_cmd_opcode_i == fe_pkg::e_op_pc_redirect);
  assign state_reset_cmd = fe_cmd_v_i & (fe_cmd_opcode_i == fe_pkg::e_op_state_reset);
  assign wait_cmd        = fe_cmd_v_i & (fe_cmd_opcode_i == fe_pkg::e_op_wait);

  // Commands are always taken at once
  assign fe_cmd_yumi_o = fe_cmd_v_i;

  // A parked wait leaves stall for wait rather than resuming
  assign unstall = (state_r == fe_pkg::e_stall) & ~fe_cmd_v_i & ~wait_pending_r
                 & fe_queue_ready_i;

  always_comb
  begin
    state_n = state_r;
    case (state_r)
      fe_pkg::e_wait:
      begin
        if (redirect_cmd)
          state_n = fe_pkg::e_run;
        else if (state_reset_cmd)
          state_n = fe_pkg::e_stall;
      end
      fe_pkg::e_run:
      begin
        if (redirect_cmd)
          state_n = fe_pkg::e_run;
        else if (fe_cmd_v_i | fetch_fail_i)
          state_n = fe_pkg::e_stall;
        else if (exc_sent_i)
          state_n = fe_pkg::e_wait;
      end
      fe_pkg::e_stall:
      begin
        if (redirect_cmd)
          state_n = fe_pkg::e_run;
        else if (fe_cmd_v_i)
          state_n = fe_pkg::e_stall;
        else if (wait_pending_r)
          state_n = fe_pkg::e_wait;
        else if (fe_queue_ready_i)
          state_n = fe_pkg::e_run;
      end
      default: state_n = fe_pkg::e_wait;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r        <= fe_pkg::e_wait;
      wait_pending_r <= 1'b0;
    end
    else
    begin
      state_r <= state_n;
      if (fe_cmd_v_i)
        wait_pending_r <= wait_cmd;
    end
  end

  // Replay point for stalls
  always_ff @(posedge clk_i)
  begin
    if (fe_cmd_v_i)
      resume_pc_r <= fe_cmd_vaddr_i;
    else if (fetch_fail_i)
      resume_pc_r <= if2_pc_i;
  end

  assign redirect_v_o  = redirect_cmd | unstall;
  assign redirect_pc_o = redirect_cmd ? fe_cmd_vaddr_i : resume_pc_r;

  // No issue in a command cycle since the new pc is loaded first
  assign issue_v_o = (state_n == fe_pkg::e_run) & ~fe_cmd_v_i;
  assign kill_o    = fe_cmd_v_i | fetch_fail_i | exc_sent_i;
  assign hold_o    = fe_cmd_v_i;

endmodule

`default_nettype wire

//--- src/fe_fetch_stage.sv
// Two-stage fetch pipeline; captures the memory answer and forms the queue message in IF2
`timescale 1ns/1ps
`default_nettype none

`include "fe_cfg.svh"

module fe_fetch_stage
(
  input  wire logic          clk_i,
  input  wire logic          reset_i,
  input  wire logic          issue_v_i,
  input  wire logic          kill_i,
  input  wire logic          hold_i,
  input  wire logic          imem_fault_i,
  input  wire logic          fe_queue_ready_i,
  input  fe_pkg::instr_t     imem_data_i,
  input  fe_pkg::vaddr_t     if2_pc_i,
  output logic               fe_queue_v_o,
  output logic               fetch_fail_o,
  output logic               exc_sent_o,
  output fe_pkg::fe_msg_e    fe_queue_msg_o,
  output fe_pkg::vaddr_t     fe_queue_pc_o,
  output fe_pkg::instr_t     fe_queue_instr_o,
  output fe_pkg::fe_exc_e    fe_queue_exc_o
);

  logic           v_if1_r;
  logic           v_if2_r;
  fe_pkg::instr_t data_if2_r;
  logic           fault_if2_r;
  logic           misaligned;
  logic           is_exc;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      v_if1_r <= 1'b0;
      v_if2_r <= 1'b0;
    end
    else
    begin
      v_if1_r <= issue_v_i;
      v_if2_r <= v_if1_r & ~kill_i;
    end
  end

  // Memory answers during IF1
  always_ff @(posedge clk_i)
  begin
    if (v_if1_r & ~kill_i)
    begin
      data_if2_r  <= imem_data_i;
      fault_if2_r <= imem_fault_i;
    end
  end

  assign misaligned = (if2_pc_i[`FE_ALIGN_BITS-1:0] != '0);
  assign is_exc     = misaligned | fault_if2_r;

  // Misaligned wins over an access fault
  assign fe_queue_exc_o   = misaligned  ? fe_pkg::e_exc_misaligned
                          : fault_if2_r ? fe_pkg::e_exc_access_fault
                          : fe_pkg::e_exc_none;
  assign fe_queue_msg_o   = is_exc ? fe_pkg::e_msg_exception : fe_pkg::e_msg_fetch;
  assign fe_queue_instr_o = is_exc ? '0 : data_if2_r;
  assign fe_queue_pc_o    = if2_pc_i;

  assign fe_queue_v_o = v_if2_r & fe_queue_ready_i & ~hold_i;
  assign fetch_fail_o = v_if2_r & ~fe_queue_v_o;
  assign exc_sent_o   = fe_queue_v_o & is_exc;

endmodule

`default_nettype wire

//--- src/fe_pc_gen.sv
// Fetch pc generator; holds the next fetch address and tracks the pcs of IF1 and IF2
`timescale 1ns/1ps
`default_nettype none

`include "fe_cfg.svh"

module fe_pc_gen
(
  input  wire logic          clk_i,
  input  wire logic          reset_i,
  input  wire logic          redirect_v_i,
  input  wire logic          issue_v_i,
  input  fe_pkg::vaddr_t     redirect_pc_i,
  output fe_pkg::vaddr_t     issue_pc_o,
  output fe_pkg::vaddr_t     if2_pc_o
);

  fe_pkg::vaddr_t pc_r;
  fe_pkg::vaddr_t pc_n;
  fe_pkg::vaddr_t if1_pc_r;
  fe_pkg::vaddr_t if2_pc_r;

  // A redirect is visible in the cycle it arrives
  assign issue_pc_o = redirect_v_i ? redirect_pc_i : pc_r;

  always_comb
  begin
    pc_n = pc_r;
    if (issue_v_i)
      pc_n = issue_pc_o + fe_pkg::vaddr_t'(`FE_INSTR_BYTES);
    else if (redirect_v_i)
      pc_n = redirect_pc_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      pc_r <= '0;
    else
      pc_r <= pc_n;
  end

  // Pc pipeline follows the issue, one and two cycles behind
  always_ff @(posedge clk_i)
  begin
    if1_pc_r <= issue_pc_o;
    if2_pc_r <= if1_pc_r;
  end

  assign if2_pc_o = if2_pc_r;

endmodule

`default_nettype wire

//--- common/fe_pkg.sv
// Shared types of the fetch front end, referenced by scoped names from the RTL
`default_nettype none

`include "fe_cfg.svh"

package fe_pkg;

  typedef logic [`FE_VADDR_WIDTH-1:0] vaddr_t;

  typedef logic [`FE_INSTR_WIDTH-1:0] instr_t;

  // Commands from the back end
  typedef enum logic [1:0]
  {
    e_op_pc_redirect = 2'd0,
    e_op_state_reset = 2'd1,
    e_op_wait        = 2'd2
  } fe_opcode_e;

  // Queue message kind
  typedef enum logic
  {
    e_msg_fetch     = 1'b0,
    e_msg_exception = 1'b1
  } fe_msg_e;

  // Exception codes carried in an exception message
  typedef enum logic [1:0]
  {
    e_exc_none         = 2'd0,
    e_exc_misaligned   = 2'd1,
    e_exc_access_fault = 2'd2
  } fe_exc_e;

  // Controller states
  typedef enum logic [1:0]
  {
    e_wait  = 2'd0,
    e_run   = 2'd1,
    e_stall = 2'd2
  } fe_state_e;

endpackage

`default_nettype wire

//--- common/fe_cfg.svh
// Width and alignment settings for the fetch front end, included by the package and RTL
`ifndef FE_CFG_SVH
`define FE_CFG_SVH

// Fetch address width
`define FE_VADDR_WIDTH 32

// Instruction word width
`define FE_INSTR_WIDTH 32

// Bytes per sequential pc step
`define FE_INSTR_BYTES 4

// Low pc bits that must be zero for an aligned fetch
`define FE_ALIGN_BITS 2

`endif
